// ==== compile.f ====
source/calcPkg.sv
source/uartRx.sv
source/uartTx.sv
source/calcStack.sv
source/calcCore.sv
source/calcControl.sv
source/miniCalc.sv
sim/miniCalc_properties.sv
sim/miniCalcTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module miniCalcTb \
    -f compile.f -o miniCalcSim > build.log 2>&1 \
    && ./obj_dir/miniCalcSim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Result: FAILED" sim.log \
    && { echo "simulation reported failure, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== sim/miniCalcTb.sv ====
`timescale 1ns/1ps

module miniCalcTb;

    localparam int bitCycles = calcPkg::clocksPerBit;
    localparam int lineLimit = 4000;

    // button sets in the order pushLow, pushHi, execute, outputHi.
    localparam logic [3:0] pushLowBtn = 4'b1000;
    localparam logic [3:0] pushHiBtn = 4'b0100;
    localparam logic [3:0] executeBtn = 4'b0010;
    localparam logic [3:0] clearBtns = 4'b0011;

    logic Clk;
    logic rst;
    logic [7:0] switch;
    logic btnPushLow;
    logic btnPushHi;
    logic btnExecute;
    logic btnOutputHi;
    logic uartRx;
    logic uartTx;
    logic ready;
    calcPkg::calcStatus_t status;

    // reference stack whose last entry is the top.
    logic [31:0] model [$];
    logic modelError;
    int errorCount;
    int checkCount;

    miniCalc i_miniCalc (
        .Clk(Clk),
        .rst(rst),
        .switch(switch),
        .btnPushLow(btnPushLow),
        .btnPushHi(btnPushHi),
        .btnExecute(btnExecute),
        .btnOutputHi(btnOutputHi),
        .uartRx(uartRx),
        .uartTx(uartTx),
        .ready(ready),
        .status(status)
    );

    initial
    begin
        Clk = 1'b0;
        forever
            #20 Clk = ~Clk;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    task automatic stepCycle();
        @(posedge Clk);
        #2;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("timeout: %s", reason);
        $display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic waitReady(input int limit);
        int cycles;
        cycles = 0;
        while (!ready)
        begin
            if (cycles == limit)
                abortRun("ready did not return high");
            stepCycle();
            cycles++;
        end
    endtask

    function automatic logic [31:0] modelTop();
        return (model.size() == 0) ? 32'h0 : model[model.size()-1];
    endfunction

    // applies one opcode to the reference stack by the operation rules.
    task automatic modelApply(input logic [7:0] opcode, input logic [31:0] operand);
        logic [31:0] a;
        logic [31:0] b;
        int needed;
        bit grows;
        bit known;
        a = modelTop();
        b = (model.size() > 1) ? model[model.size()-2] : 32'h0;
        grows = (opcode == calcPkg::opPush) || (opcode == calcPkg::opCopy);
        known = 1'b1;
        case (opcode)
            calcPkg::opPush, calcPkg::opClear:
                needed = 0;
            calcPkg::opAppend, calcPkg::opPop, calcPkg::opCopy:
                needed = 1;
            calcPkg::opAdd, calcPkg::opSub, calcPkg::opMul, calcPkg::opDiv,
            calcPkg::opMod, calcPkg::opSwap:
                needed = 2;
            default:
            begin
                needed = 0;
                known = 1'b0;
            end
        endcase
        modelError = !known || (model.size() < needed) ||
                     (grows && model.size() == calcPkg::stackDepth) ||
                     ((opcode == calcPkg::opDiv || opcode == calcPkg::opMod) && a == 0);
        if (!modelError)
        begin
            case (opcode)
                calcPkg::opPush:
                    model.push_back(operand);
                calcPkg::opAppend:
                    model[model.size()-1] = {a[23:0], operand[7:0]};
                calcPkg::opPop:
                    void'(model.pop_back());
                calcPkg::opCopy:
                    model.push_back(a);
                calcPkg::opSwap:
                begin
                    model[model.size()-1] = b;
                    model[model.size()-2] = a;
                end
                calcPkg::opClear:
                    model.delete();
                default:
                begin
                    void'(model.pop_back());
                    void'(model.pop_back());
                    case (opcode)
                        calcPkg::opAdd: model.push_back(b + a);
                        calcPkg::opSub: model.push_back(b - a);
                        calcPkg::opMul: model.push_back(b * a);
                        calcPkg::opDiv: model.push_back(b / a);
                        default: model.push_back(b % a);
                    endcase
                end
            endcase
        end
    endtask

    task automatic checkStatus();
        checkValue("status.top", status.top, modelTop());
        checkValue("status.depth", status.depth, model.size());
        checkValue("status.empty", status.empty, model.size() == 0);
        checkValue("status.error", status.error, modelError);
    endtask

    // holds a button set for one sampled edge, then waits for idle.
    task automatic runButton(input logic [3:0] buttons, input logic [7:0] value,
                             input logic [7:0] expectOp);
        waitReady(lineLimit);
        switch = value;
        {btnPushLow, btnPushHi, btnExecute, btnOutputHi} = buttons;
        stepCycle();
        checkValue("ready", ready, 1'b0);
        {btnPushLow, btnPushHi, btnExecute, btnOutputHi} = 4'b0000;
        waitReady(5);
        modelApply(expectOp, {24'h0, value});
        checkStatus();
    endtask

    // ----------------------------------------------------------------------
    // serial line
    // ----------------------------------------------------------------------

    task automatic sendByte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            uartRx = bits[i];
            repeat (bitCycles)
                stepCycle();
        end
    endtask

    task automatic sendFrame(input logic [7:0] opcode, input logic [31:0] operand);
        sendByte(opcode);
        for (int i = 3; i >= 0; i--)
            sendByte(operand[i*8 +: 8]);
    endtask

    task automatic receiveByte(output logic [7:0] value);
        int cycles;
        cycles = 0;
        while (uartTx)
        begin
            if (cycles == lineLimit)
                abortRun("no start bit seen on uartTx");
            stepCycle();
            cycles++;
        end
        // sample every bit near its middle.
        repeat (bitCycles / 2)
            stepCycle();
        if (uartTx)
        begin
            errorCount++;
            $display("start bit on uartTx did not last half a bit");
        end
        for (int i = 0; i < 8; i++)
        begin
            repeat (bitCycles)
                stepCycle();
            value[i] = uartTx;
        end
        repeat (bitCycles)
            stepCycle();
        if (!uartTx)
        begin
            errorCount++;
            $display("stop bit on uartTx was low");
        end
    endtask

    task automatic receiveWord(output logic [31:0] word);
        logic [7:0] value;
        word = '0;
        for (int i = 0; i < calcPkg::respBytes; i++)
        begin
            receiveByte(value);
            word = {word[23:0], value};
        end
    endtask

    task automatic uartCommand(input logic [7:0] opcode, input logic [31:0] operand);
        logic [31:0] response;
        waitReady(lineLimit);
        fork
            sendFrame(opcode, operand);
            receiveWord(response);
        join
        modelApply(opcode, operand);
        checkValue("response", response, modelTop());
        // ready comes back once the last stop bit has ended.
        waitReady(bitCycles);
        checkStatus();
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic resetDefaults();
        checkValue("ready", ready, 1'b1);
        checkValue("uartTx", uartTx, 1'b1);
        checkStatus();
    endtask

    task automatic pushAndAppend();
        logic [7:0] low;
        logic [7:0] high;
        low = 8'($urandom);
        high = 8'($urandom);
        runButton(pushLowBtn, low, calcPkg::opPush);
        runButton(pushHiBtn, high, calcPkg::opAppend);
        checkValue("status.top", status.top, {16'h0, low, high});
        checkValue("status.depth", status.depth, 1);
    endtask

    task automatic executeBySwitch();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] expectOp [0:4];
        expectOp = '{calcPkg::opAdd, calcPkg::opSub, calcPkg::opMul,
                     calcPkg::opDiv, calcPkg::opMod};
        for (int code = 0; code < 5; code++)
        begin
            a = 8'($urandom);
            b = 8'($urandom % 255 + 1);
            runButton(clearBtns, 8'h00, calcPkg::opClear);
            runButton(pushLowBtn, a, calcPkg::opPush);
            runButton(pushLowBtn, b, calcPkg::opPush);
            // only the low three switch bits select the opcode.
            runButton(executeBtn, {5'($urandom), 3'(code)}, expectOp[code]);
        end
        a = 8'($urandom);
        b = ~a;
        runButton(clearBtns, 8'h00, calcPkg::opClear);
        runButton(pushLowBtn, a, calcPkg::opPush);
        runButton(pushLowBtn, b, calcPkg::opPush);
        runButton(executeBtn, 8'd7, calcPkg::opSwap);
        checkValue("status.top", status.top, {24'h0, a});
        runButton(executeBtn, 8'd5, calcPkg::opPop);
        checkValue("status.top", status.top, {24'h0, b});
        runButton(executeBtn, 8'd6, calcPkg::opCopy);
        checkValue("status.depth", status.depth, 2);
        runButton(executeBtn, 8'd5, calcPkg::opPop);
        checkValue("status.top", status.top, {24'h0, b});
        runButton(clearBtns, 8'($urandom), calcPkg::opClear);
        checkValue("status.empty", status.empty, 1'b1);
    endtask

    task automatic errorFlagRules();
        logic [7:0] a;
        a = 8'($urandom % 255 + 1);
        runButton(clearBtns, 8'h00, calcPkg::opClear);
        runButton(pushLowBtn, a, calcPkg::opPush);
        runButton(executeBtn, 8'd0, calcPkg::opAdd);
        checkValue("status.error", status.error, 1'b1);
        runButton(pushLowBtn, 8'h00, calcPkg::opPush);
        checkValue("status.error", status.error, 1'b0);
        runButton(executeBtn, 8'd3, calcPkg::opDiv);
        checkValue("status.error", status.error, 1'b1);
        runButton(executeBtn, 8'd5, calcPkg::opPop);
        uartCommand(8'h7E, $urandom);
        checkValue("status.error", status.error, 1'b1);
        runButton(pushLowBtn, a, calcPkg::opPush);
        checkValue("status.error", status.error, 1'b0);
    endtask

    task automatic uartFrames();
        logic [7:0] x;
        logic [31:0] operand;
        x = 8'($urandom);
        operand = $urandom;
        runButton(clearBtns, 8'h00, calcPkg::opClear);
        runButton(pushLowBtn, x, calcPkg::opPush);
        uartCommand(calcPkg::opPush, operand);
        uartCommand(calcPkg::opAdd, $urandom);
        checkValue("status.top", status.top, operand + {24'h0, x});
    endtask

    task automatic frameBufferFlush();
        logic [7:0] s;
        logic [31:0] operand;
        s = 8'($urandom);
        operand = $urandom;
        runButton(clearBtns, 8'h00, calcPkg::opClear);
        sendByte(calcPkg::opPush);
        sendByte(8'($urandom));
        sendByte(8'($urandom));
        runButton(pushLowBtn, s, calcPkg::opPush);
        uartCommand(calcPkg::opPush, operand);
        checkValue("status.depth", status.depth, 2);
        checkValue("status.top", status.top, operand);
        runButton(executeBtn, 8'd5, calcPkg::opPop);
        checkValue("status.top", status.top, {24'h0, s});
    endtask

    initial
    begin
        void'($urandom(32'h3f4f3d7c));
        errorCount = 0;
        checkCount = 0;
        modelError = 1'b0;
        rst = 1'b1;
        switch = 8'h00;
        btnPushLow = 1'b0;
        btnPushHi = 1'b0;
        btnExecute = 1'b0;
        btnOutputHi = 1'b0;
        uartRx = 1'b1;
        repeat (8)
            @(posedge Clk);
        #2;
        rst = 1'b0;
        stepCycle();
        resetDefaults();
        pushAndAppend();
        executeBySwitch();
        errorFlagRules();
        uartFrames();
        frameBufferFlush();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sim/miniCalc_properties.sv ====
`timescale 1ns/1ps

module miniCalc_properties (
    input logic Clk,
    input logic rst,
    input logic txStart,
    input logic txBusy,
    input logic start,
    input logic coreBusy,
    input logic uartTx
);

    txStartWhenFree: assert property (@(posedge Clk) disable iff (rst)
        txStart |-> !txBusy)
        else $error("txStart pulsed while the transmitter was busy");

    startWhenIdle: assert property (@(posedge Clk) disable iff (rst)
        start |-> !coreBusy)
        else $error("start pulsed while the core was busy");

    // the core is busy for two cycles after it takes a start.
    busyTwoCycles: assert property (@(posedge Clk) disable iff (rst)
        start |=> coreBusy ##1 coreBusy ##1 !coreBusy)
        else $error("core busy did not fall two cycles after start");

    lineIdleHigh: assert property (@(posedge Clk) disable iff (rst)
        !txBusy |-> uartTx)
        else $error("uartTx low while the transmitter was idle");

endmodule

bind miniCalc miniCalc_properties i_miniCalcProperties (
    .Clk(Clk),
    .rst(rst),
    .txStart(txStart),
    .txBusy(txBusy),
    .start(start),
    .coreBusy(coreBusy),
    .uartTx(uartTx)
);

// ==== source/calcControl.sv ====
`timescale 1ns/1ps

module calcControl (
    input  logic Clk,
    input  logic rst,
    input  logic [7:0] switch,
    input  logic btnPushLow,
    input  logic btnPushHi,
    input  logic btnExecute,
    input  logic btnOutputHi,
    input  logic rxValid,
    input  logic [7:0] rxByte,
    input  logic txBusy,
    output logic txStart,
    output logic [7:0] txByte,
    output calcPkg::calcCmd_t cmd,
    output logic start,
    input  logic coreBusy,
    input  logic [calcPkg::wordWidth-1:0] coreTop,
    output logic ready
);

    typedef enum logic [1:0] {stateIdle, stateExecute, stateWait, stateRespond} ctrlState_t;

    ctrlState_t state;
    calcPkg::calcCmd_t btnCmd;
    logic btnHit;
    logic [(calcPkg::frameBytes-1)*8-1:0] frameHead;
    logic [2:0] frameCount;
    logic respOwed;
    logic [2:0] respCount;
    logic [calcPkg::wordWidth-1:0] respWord;

    // button priority: push low, push high, clear, then execute by switch.
    always_comb
    begin
        btnCmd = '0;
        btnHit = 1'b1;
        if (btnPushLow)
        begin
            btnCmd.opcode = calcPkg::opPush;
            btnCmd.operand = {{(calcPkg::wordWidth-8){1'b0}}, switch};
        end
        else if (btnPushHi)
        begin
            btnCmd.opcode = calcPkg::opAppend;
            btnCmd.operand = {{(calcPkg::wordWidth-8){1'b0}}, switch};
        end
        else if (btnExecute && btnOutputHi)
            btnCmd.opcode = calcPkg::opClear;
        else if (btnExecute)
            btnCmd.opcode = calcPkg::execOpcodes[switch[2:0]];
        else
            btnHit = 1'b0;
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state <= stateIdle;
            frameCount <= '0;
            respOwed <= 1'b0;
            respCount <= '0;
            txStart <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            txStart <= 1'b0;
            start <= 1'b0;
            case (state)
                stateIdle:
                begin
                    if (btnHit)
                    begin
                        cmd <= btnCmd;
                        start <= 1'b1;
                        respOwed <= 1'b0;
                        frameCount <= '0;
                        state <= stateExecute;
                    end
                    else if (rxValid)
                    begin
                        // the fifth byte completes the frame and goes out at once.
                        if (frameCount == 3'(calcPkg::frameBytes - 1))
                        begin
                            cmd <= {frameHead, rxByte};
                            start <= 1'b1;
                            respOwed <= 1'b1;
                            frameCount <= '0;
                            state <= stateExecute;
                        end
                        else
                        begin
                            frameHead <= {frameHead[(calcPkg::frameBytes-2)*8-1:0], rxByte};
                            frameCount <= frameCount + 1'b1;
                        end
                    end
                end
                stateExecute:
                    state <= stateWait;
                stateWait:
                begin
                    if (!coreBusy)
                    begin
                        respWord <= coreTop;
                        respCount <= '0;
                        state <= respOwed ? stateRespond : stateIdle;
                    end
                end
                default:
                begin
                    // one byte per free transmitter, most significant first.
                    if (!txBusy && !txStart)
                    begin
                        if (respCount == 3'(calcPkg::respBytes))
                        begin
                            respOwed <= 1'b0;
                            state <= stateIdle;
                        end
                        else
                        begin
                            txStart <= 1'b1;
                            txByte <= respWord[calcPkg::wordWidth-1 -: 8];
                            respWord <= respWord << 8;
                            respCount <= respCount + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign ready = (state == stateIdle);

endmodule

// ==== source/calcCore.sv ====
`timescale 1ns/1ps

module calcCore (
    input  logic Clk,
    input  logic rst,
    input  calcPkg::calcCmd_t cmd,
    input  logic start,
    output logic busy,
    output calcPkg::calcStatus_t status
);

    typedef logic [calcPkg::depthWidth-1:0] count_t;

    calcPkg::calcCmd_t cmdReg;
    logic phase;
    logic fault;
    logic faultNow;
    logic error;
    count_t needed;
    logic grows;
    logic known;
    logic divZero;

    logic pop1;
    logic pop2;
    logic push;
    logic clear;
    logic [calcPkg::wordWidth-1:0] pushData;
    logic [calcPkg::wordWidth-1:0] top;
    logic [calcPkg::wordWidth-1:0] second;
    count_t depth;

    calcStack i_calcStack (
        .Clk(Clk),
        .rst(rst),
        .pop1(pop1),
        .pop2(pop2),
        .push(push),
        .clear(clear),
        .pushData(pushData),
        .top(top),
        .second(second),
        .depth(depth)
    );

    // ----------------------------------------------------------------------
    // first cycle: fault check against the current depth
    // ----------------------------------------------------------------------

    always_comb
    begin
        needed = '0;
        grows = 1'b0;
        known = 1'b1;
        divZero = 1'b0;
        case (cmdReg.opcode)
            calcPkg::opPush:
                grows = 1'b1;
            calcPkg::opAppend, calcPkg::opPop:
                needed = count_t'(1);
            calcPkg::opCopy:
            begin
                needed = count_t'(1);
                grows = 1'b1;
            end
            calcPkg::opAdd, calcPkg::opSub, calcPkg::opMul, calcPkg::opSwap:
                needed = count_t'(2);
            calcPkg::opDiv, calcPkg::opMod:
            begin
                needed = count_t'(2);
                divZero = (top == '0);
            end
            calcPkg::opClear:
                needed = '0;
            default:
                known = 1'b0;
        endcase
        faultNow = !known || divZero || (depth < needed) ||
                   (grows && depth == count_t'(calcPkg::stackDepth));
    end

    // ----------------------------------------------------------------------
    // second cycle: result and stack request
    // ----------------------------------------------------------------------

    always_comb
    begin
        pop1 = 1'b0;
        pop2 = 1'b0;
        push = 1'b0;
        clear = 1'b0;
        pushData = cmdReg.operand;
        if (busy && phase && !fault)
        begin
            case (cmdReg.opcode)
                calcPkg::opPush:
                    push = 1'b1;
                calcPkg::opAppend:
                begin
                    pop1 = 1'b1;
                    push = 1'b1;
                    pushData = {top[calcPkg::wordWidth-9:0], cmdReg.operand[7:0]};
                end
                calcPkg::opAdd, calcPkg::opSub, calcPkg::opMul,
                calcPkg::opDiv, calcPkg::opMod:
                begin
                    pop1 = 1'b1;
                    pop2 = 1'b1;
                    push = 1'b1;
                    case (cmdReg.opcode)
                        calcPkg::opAdd: pushData = second + top;
                        calcPkg::opSub: pushData = second - top;
                        calcPkg::opMul: pushData = second * top;
                        calcPkg::opDiv: pushData = second / top;
                        default: pushData = second % top;
                    endcase
                end
                calcPkg::opPop:
                    pop1 = 1'b1;
                calcPkg::opCopy:
                begin
                    push = 1'b1;
                    pushData = top;
                end
                calcPkg::opSwap:
                begin
                    // drop the second word and put it back on top.
                    pop2 = 1'b1;
                    push = 1'b1;
                    pushData = second;
                end
                calcPkg::opClear:
                    clear = 1'b1;
                default:
                    clear = 1'b0;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            phase <= 1'b0;
            fault <= 1'b0;
            error <= 1'b0;
        end
        else if (!busy)
        begin
            busy <= start;
            phase <= 1'b0;
        end
        else if (!phase)
        begin
            phase <= 1'b1;
            fault <= faultNow;
        end
        else
        begin
            // the stack and the flag change together on this edge.
            busy <= 1'b0;
            phase <= 1'b0;
            error <= fault;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (start && !busy)
            cmdReg <= cmd;
    end

    always_comb
    begin
        status.top = (depth == '0) ? '0 : top;
        status.depth = depth;
        status.empty = (depth == '0);
        status.error = error;
    end

endmodule

// ==== source/calcPkg.sv ====
package calcPkg;

    // ----------------------------------------------------------------------
    // sizes
    // ----------------------------------------------------------------------

    localparam int wordWidth = 32;
    localparam int stackDepth = 16;
    localparam int stackAddrWidth = 4;

    // one bit wider than the address so a full stack can be reported.
    localparam int depthWidth = 5;

    localparam int frameBytes = 5;
    localparam int respBytes = 4;

    // bit time of the serial line in clock cycles.
    localparam int clocksPerBit = 16;

    // ----------------------------------------------------------------------
    // opcodes
    // ----------------------------------------------------------------------

    localparam logic [7:0] opPush = 8'h01;
    localparam logic [7:0] opPop = 8'h02;
    localparam logic [7:0] opCopy = 8'h03;
    localparam logic [7:0] opAdd = 8'h04;
    localparam logic [7:0] opSub = 8'h05;
    localparam logic [7:0] opMul = 8'h06;
    localparam logic [7:0] opDiv = 8'h08;
    localparam logic [7:0] opSwap = 8'h09;
    localparam logic [7:0] opMod = 8'h0A;
    localparam logic [7:0] opAppend = 8'h21;
    localparam logic [7:0] opClear = 8'h80;

    // opcode run by the execute button, indexed by the low three switch bits.
    localparam logic [7:0] execOpcodes [0:7] = '{
        opAdd, opSub, opMul, opDiv, opMod, opPop, opCopy, opSwap
    };

    typedef struct packed {
        logic [7:0] opcode;
        logic [wordWidth-1:0] operand;
    } calcCmd_t;

    typedef struct packed {
        logic [wordWidth-1:0] top;
        logic [depthWidth-1:0] depth;
        logic empty;
        logic error;
    } calcStatus_t;

endpackage

// ==== source/calcStack.sv ====
`timescale 1ns/1ps

module calcStack (
    input  logic Clk,
    input  logic rst,
    input  logic pop1,
    input  logic pop2,
    input  logic push,
    input  logic clear,
    input  logic [calcPkg::wordWidth-1:0] pushData,
    output logic [calcPkg::wordWidth-1:0] top,
    output logic [calcPkg::wordWidth-1:0] second,
    output logic [calcPkg::depthWidth-1:0] depth
);

    typedef logic [calcPkg::stackAddrWidth-1:0] addr_t;
    typedef logic [calcPkg::depthWidth-1:0] count_t;

    logic [calcPkg::wordWidth-1:0] mem [calcPkg::stackDepth];
    count_t count;
    count_t afterPop;
    addr_t topAddr;
    addr_t secondAddr;
    addr_t pushAddr;

    // pop1 removes the top word and pop2 the word below it. a push then
    // lands on the shortened stack, so one request covers a whole operation.
    always_comb
    begin
        topAddr = addr_t'(count - 1'b1);
        secondAddr = addr_t'(count - 2'd2);
        afterPop = count - count_t'(pop1) - count_t'(pop2);
        pushAddr = addr_t'(afterPop);
    end

    always_ff @(posedge Clk)
    begin
        if (rst || clear)
            count <= '0;
        else
            count <= afterPop + count_t'(push);
    end

    always_ff @(posedge Clk)
    begin
        if (!clear)
        begin
            // removing only the second word writes the top back one slot down.
            if (pop2 && !pop1)
                mem[secondAddr] <= mem[topAddr];
            if (push)
                mem[pushAddr] <= pushData;
        end
    end

    assign top = mem[topAddr];
    assign second = mem[secondAddr];
    assign depth = count;

endmodule

// ==== source/miniCalc.sv ====
`timescale 1ns/1ps

module miniCalc (
    input  logic Clk,
    input  logic rst,
    input  logic [7:0] switch,
    input  logic btnPushLow,
    input  logic btnPushHi,
    input  logic btnExecute,
    input  logic btnOutputHi,
    input  logic uartRx,
    output logic uartTx,
    output logic ready,
    output calcPkg::calcStatus_t status
);

    logic rxValid;
    logic [7:0] rxByte;
    logic txStart;
    logic [7:0] txByte;
    logic txBusy;
    calcPkg::calcCmd_t cmd;
    logic start;
    logic coreBusy;

    uartRx i_uartRx (
        .Clk(Clk),
        .rst(rst),
        .uartRx(uartRx),
        .rxValid(rxValid),
        .rxByte(rxByte)
    );

    uartTx i_uartTx (
        .Clk(Clk),
        .rst(rst),
        .txStart(txStart),
        .txByte(txByte),
        .uartTx(uartTx),
        .txBusy(txBusy)
    );

    calcControl i_calcControl (
        .Clk(Clk),
        .rst(rst),
        .switch(switch),
        .btnPushLow(btnPushLow),
        .btnPushHi(btnPushHi),
        .btnExecute(btnExecute),
        .btnOutputHi(btnOutputHi),
        .rxValid(rxValid),
        .rxByte(rxByte),
        .txBusy(txBusy),
        .txStart(txStart),
        .txByte(txByte),
        .cmd(cmd),
        .start(start),
        .coreBusy(coreBusy),
        .coreTop(status.top),
        .ready(ready)
    );

    calcCore i_calcCore (
        .Clk(Clk),
        .rst(rst),
        .cmd(cmd),
        .start(start),
        .busy(coreBusy),
        .status(status)
    );

endmodule

// ==== source/uartRx.sv ====
`timescale 1ns/1ps

module uartRx (
    input  logic Clk,
    input  logic rst,
    input  logic uartRx,
    output logic rxValid,
    output logic [7:0] rxByte
);

    typedef logic [$clog2(calcPkg::clocksPerBit)-1:0] timer_t;
    typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_t;

    rxState_t state;
    timer_t bitTimer;
    logic [2:0] bitIndex;
    logic [1:0] lineSync;
    logic line;
    logic bitEnd;

    assign line = lineSync[1];
    assign bitEnd = (bitTimer == timer_t'(calcPkg::clocksPerBit - 1));

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state <= rxIdle;
            bitTimer <= '0;
            bitIndex <= '0;
            lineSync <= 2'b11;
            rxValid <= 1'b0;
        end
        else
        begin
            lineSync <= {lineSync[0], uartRx};
            rxValid <= 1'b0;
            bitTimer <= bitTimer + 1'b1;
            case (state)
                rxIdle:
                begin
                    bitTimer <= '0;
                    if (!line)
                        state <= rxStart;
                end
                rxStart:
                begin
                    // re-check the start bit half a bit later to reject glitches.
                    if (bitTimer == timer_t'(calcPkg::clocksPerBit / 2 - 1))
                    begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        state <= line ? rxIdle : rxData;
                    end
                end
                rxData:
                begin
                    if (bitEnd)
                    begin
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7)
                            state <= rxStop;
                    end
                end
                default:
                begin
                    if (bitEnd)
                    begin
                        rxValid <= line;
                        state <= rxIdle;
                    end
                end
            endcase
        end
    end

    // data arrives least significant bit first.
    always_ff @(posedge Clk)
    begin
        if (state == rxData && bitEnd)
            rxByte <= {line, rxByte[7:1]};
    end

endmodule

// ==== source/uartTx.sv ====
`timescale 1ns/1ps

module uartTx (
    input  logic Clk,
    input  logic rst,
    input  logic txStart,
    input  logic [7:0] txByte,
    output logic uartTx,
    output logic txBusy
);

    typedef logic [$clog2(calcPkg::clocksPerBit)-1:0] timer_t;

    timer_t bitTimer;
    logic [3:0] bitCount;
    logic [9:0] frameShift;
    logic bitEnd;

    assign bitEnd = (bitTimer == timer_t'(calcPkg::clocksPerBit - 1));

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            txBusy <= 1'b0;
            bitTimer <= '0;
            bitCount <= '0;
        end
        else if (!txBusy)
        begin
            bitTimer <= '0;
            bitCount <= '0;
            txBusy <= txStart;
        end
        else if (bitEnd)
        begin
            bitTimer <= '0;
            bitCount <= bitCount + 1'b1;
            if (bitCount == 4'd9)
                txBusy <= 1'b0;
        end
        else
        begin
            bitTimer <= bitTimer + 1'b1;
        end
    end

    // the frame holds stop bit, data and start bit, and bit 0 is on the line.
    always_ff @(posedge Clk)
    begin
        if (rst)
            frameShift <= '1;
        else if (!txBusy && txStart)
            frameShift <= {1'b1, txByte, 1'b0};
        else if (txBusy && bitEnd)
            frameShift <= {1'b1, frameShift[9:1]};
    end

    // ones shift in behind the stop bit, so the line rests high when idle.
    assign uartTx = frameShift[0];

endmodule
